//--- verilog/timing_pkg.sv
`default_nettype none

// shared widths and types for the symbol timing stage
package timing_pkg;

  // ----------------------------------------
  // widths with a fixed meaning
  // ----------------------------------------
  localparam int SAMPLE_W  = 16;  // raw adc sample
  localparam int SYM_W     = 18;  // interpolated symbol, 2 extra frac bits
  localparam int MU_W      = 8;   // fractional delay, units of 1/256 sample
  localparam int MU_GAIN_W = 12;  // mu gain, Q4.8

  // ----------------------------------------
  // types
  // ----------------------------------------

  // signed raw sample, one rail
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // signed symbol value, sample scaled by 4
  typedef logic signed [SYM_W-1:0] sym_t;

  // 0..255 means 0..255/256 of a raw period
  typedef logic [MU_W-1:0] mu_t;

  // unsigned Q4.8, 256 is unity
  typedef logic [MU_GAIN_W-1:0] mu_gain_t;

endpackage

`default_nettype wire

//--- verilog/symbol_nco.sv
`timescale 1ns/1ps
`default_nettype none

// phase accumulator timing generator
// marks the raw sample that carries a symbol instant and derives mu
module symbol_nco #(
  parameter int PHASE_W = 16  // accumulator width, at least MU_W
) (
  input  wire                        clk,
  input  wire                        reset_i,
  input  wire                        raw_valid_i,
  input  wire                        raw_ready_i,  // credit from joiner
  input  timing_pkg::sample_t        raw_i_i,
  input  timing_pkg::sample_t        raw_q_i,
  input  wire          [PHASE_W-1:0] step_i,       // phase advance per sample
  input  timing_pkg::mu_gain_t       mu_gain_i,
  output logic                       smp_valid_o,
  output timing_pkg::sample_t        smp_i_o,
  output timing_pkg::sample_t        smp_q_o,
  output logic                       sym_strobe_o,
  output timing_pkg::mu_t            mu_o
);

  localparam int MU_W   = timing_pkg::MU_W;
  localparam int PROD_W = timing_pkg::MU_W + timing_pkg::MU_GAIN_W;  // 20

  logic               accept;
  logic [PHASE_W:0]   phase_sum;   // one extra bit catches the wrap
  logic               wrap;
  logic [MU_W-1:0]    resid_top;   // top bits of residual phase
  logic [PROD_W-1:0]  mu_prod;     // residual * gain, Q.16
  timing_pkg::mu_t    mu_sat;
  logic [PHASE_W-1:0] acc_q;

  assign accept = raw_valid_i & raw_ready_i;

  // ----------------------------------------
  // phase step and wrap detect
  // ----------------------------------------
  assign phase_sum = {1'b0, acc_q} + {1'b0, step_i};
  assign wrap      = phase_sum[PHASE_W];             // carry out = symbol instant
  assign resid_top = phase_sum[PHASE_W-1 -: MU_W];   // residual after the wrap

  // mu = (resid_top * gain) >> 8, clipped to 255
  assign mu_prod = resid_top * mu_gain_i;
  assign mu_sat  = (|mu_prod[PROD_W-1:2*MU_W]) ? '1   // gain > 1.0 overshoot
                                               : mu_prod[2*MU_W-1:MU_W];

  // ----------------------------------------
  // control state
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset_i) begin
      acc_q        <= '0;
      smp_valid_o  <= 1'b0;
      sym_strobe_o <= 1'b0;
    end else begin
      if (accept) begin
        acc_q <= phase_sum[PHASE_W-1:0];  // modulo 2^PHASE_W
      end
      smp_valid_o  <= accept;
      sym_strobe_o <= accept & wrap;      // only on accepted samples
    end
  end

  // sample, strobe and mu leave on the same edge
  // so both rails share one timeline
  always_ff @(posedge clk) begin
    if (accept) begin
      smp_i_o <= raw_i_i;
      smp_q_o <= raw_q_i;
      mu_o    <= mu_sat;   // don't care unless strobe set
    end
  end

endmodule

`default_nettype wire

//--- verilog/rail_interp.sv
`timescale 1ns/1ps
`default_nettype none

// one rail of the linear interpolator
// y = (newest*(256-mu) + previous*mu) >>> 6, floor rounding
// used twice, once for I and once for Q
module rail_interp (
  input  wire                 clk,
  input  wire                 reset_i,
  input  wire                 smp_valid_i,   // shift history
  input  timing_pkg::sample_t smp_i,
  input  wire                 sym_strobe_i,  // interpolate at this sample
  input  timing_pkg::mu_t     mu_i,
  output logic                rail_valid_o,
  output timing_pkg::sym_t    rail_o
);

  localparam int SAMPLE_W = timing_pkg::SAMPLE_W;
  localparam int MU_W     = timing_pkg::MU_W;
  localparam int SYM_W    = timing_pkg::SYM_W;
  localparam int WGT_W    = MU_W + 1;            // 256-mu needs 9 bits
  localparam int PROD_W   = SAMPLE_W + MU_W + 2; // product plus sign plus sum growth
  localparam int SHIFT    = MU_W - (SYM_W - SAMPLE_W);  // 8 - 2 = 6

  // ----------------------------------------
  // history
  // ----------------------------------------
  // newest = the sample being presented, previous = last one shifted in
  timing_pkg::sample_t prev_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      prev_q <= '0;            // zero history after reset
    end else if (smp_valid_i) begin
      prev_q <= smp_i;
    end
  end

  // ----------------------------------------
  // stage 1: weighted products
  // ----------------------------------------
  logic        [WGT_W-1:0]  wgt_new;   // 256 - mu, range 1..256
  logic signed [PROD_W-1:0] prod_new;
  logic signed [PROD_W-1:0] prod_prev;
  logic signed [PROD_W-1:0] p_new_q;
  logic signed [PROD_W-1:0] p_prev_q;
  logic                     s1_valid_q;

  assign wgt_new   = {1'b1, {MU_W{1'b0}}} - {1'b0, mu_i};
  assign prod_new  = smp_i  * $signed({1'b0, wgt_new});  // weights kept positive
  assign prod_prev = prev_q * $signed({1'b0, mu_i});

  always_ff @(posedge clk) begin
    if (sym_strobe_i) begin
      p_new_q  <= prod_new;
      p_prev_q <= prod_prev;
    end
  end

  // ----------------------------------------
  // stage 2: sum and scale
  // ----------------------------------------
  logic signed [PROD_W-1:0] wsum;
  logic signed [PROD_W-1:0] wsum_sh;

  assign wsum    = p_new_q + p_prev_q;  // at most 256 * |sample|
  assign wsum_sh = wsum >>> SHIFT;      // arithmetic, rounds toward -inf

  always_ff @(posedge clk) begin
    if (s1_valid_q) begin
      rail_o <= wsum_sh[SYM_W-1:0];     // fits, 256*32768 >> 6 = 2^17
    end
  end

  // valid lanes, fixed 2 cycle latency
  always_ff @(posedge clk) begin
    if (reset_i) begin
      s1_valid_q   <= 1'b0;
      rail_valid_o <= 1'b0;
    end else begin
      s1_valid_q   <= sym_strobe_i;
      rail_valid_o <= s1_valid_q;
    end
  end

endmodule

`default_nettype wire

//--- verilog/symbol_joiner.sv
`timescale 1ns/1ps
`default_nettype none

// joins the I and Q rail results into one symbol queue
// input throttled by credits so the queue can't overflow
module symbol_joiner #(
  parameter int FIFO_DEPTH = 4  // at least 2
) (
  input  wire              clk,
  input  wire              reset_i,
  input  wire              sym_strobe_i,  // symbol entering the rails
  input  wire              i_valid_i,
  input  timing_pkg::sym_t i_sym_i,
  input  wire              q_valid_i,
  input  timing_pkg::sym_t q_sym_i,
  input  wire              sym_ready_i,
  output logic             raw_ready_o,
  output logic             sym_valid_o,
  output timing_pkg::sym_t sym_i_o,
  output timing_pkg::sym_t sym_q_o
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);  // holds 0..FIFO_DEPTH

  // one sample accepted after the threshold can still add a symbol
  // and another is in the generator, hence depth minus 2
  localparam logic [CNT_W-1:0] CREDIT_MAX = CNT_W'(FIFO_DEPTH - 2);

  timing_pkg::sym_t  mem_i [FIFO_DEPTH];
  timing_pkg::sym_t  mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  fill_q;     // queue occupancy
  logic [CNT_W-1:0]  credit_q;   // occupancy + symbols in the rails
  logic              wr_en;
  logic              rd_en;

  assign wr_en = i_valid_i & q_valid_i;   // rails always line up
  assign rd_en = sym_valid_o & sym_ready_i;

  // ----------------------------------------
  // queue storage, no reset on payload
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem_i[wr_ptr_q] <= i_sym_i;
      mem_q[wr_ptr_q] <= q_sym_i;
    end
  end

  // ----------------------------------------
  // pointers, fill and credit
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
      credit_q <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   fill_q <= fill_q + 1'b1;
        2'b01:   fill_q <= fill_q - 1'b1;
        default: fill_q <= fill_q;        // both or neither
      endcase
      // credit taken at the strobe, returned when the symbol leaves
      case ({sym_strobe_i, rd_en})
        2'b10:   credit_q <= credit_q + 1'b1;
        2'b01:   credit_q <= credit_q - 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  // ----------------------------------------
  // outputs
  // ----------------------------------------
  assign raw_ready_o = (credit_q <= CREDIT_MAX);
  assign sym_valid_o = (fill_q != '0);
  assign sym_i_o     = mem_i[rd_ptr_q];   // head stays put until taken
  assign sym_q_o     = mem_q[rd_ptr_q];

endmodule

`default_nettype wire

//--- verilog/timing_recovery_top.sv
`timescale 1ns/1ps
`default_nettype none

// symbol timing interpolation stage
// generator -> I and Q rails -> joiner queue
module timing_recovery_top #(
  parameter int PHASE_W    = 16,  // timing accumulator width
  parameter int FIFO_DEPTH = 4    // symbol queue depth
) (
  input  wire                        clk,
  input  wire                        reset_i,
  input  wire                        raw_valid_i,
  input  timing_pkg::sample_t        raw_i_i,
  input  timing_pkg::sample_t        raw_q_i,
  input  wire          [PHASE_W-1:0] step_i,     // 2^PHASE_W / samples per symbol
  input  timing_pkg::mu_gain_t       mu_gain_i,  // Q4.8
  input  wire                        sym_ready_i,
  output logic                       raw_ready_o,
  output logic                       sym_valid_o,
  output timing_pkg::sym_t           sym_i_o,
  output timing_pkg::sym_t           sym_q_o
);

  // ----------------------------------------
  // generator to rails
  // ----------------------------------------
  logic                smp_valid;
  timing_pkg::sample_t smp_i;
  timing_pkg::sample_t smp_q;
  logic                sym_strobe;   // also feeds the joiner credits
  timing_pkg::mu_t     mu;

  // rails to joiner
  logic                rail_i_valid;
  timing_pkg::sym_t    rail_i;
  logic                rail_q_valid;
  timing_pkg::sym_t    rail_q;

  symbol_nco #(
    .PHASE_W (PHASE_W)
  ) i_symbol_nco (
    .clk          (clk),
    .reset_i      (reset_i),
    .raw_valid_i  (raw_valid_i),
    .raw_ready_i  (raw_ready_o),   // credit gate from the joiner
    .raw_i_i      (raw_i_i),
    .raw_q_i      (raw_q_i),
    .step_i       (step_i),
    .mu_gain_i    (mu_gain_i),
    .smp_valid_o  (smp_valid),
    .smp_i_o      (smp_i),
    .smp_q_o      (smp_q),
    .sym_strobe_o (sym_strobe),
    .mu_o         (mu)
  );

  // in-phase rail
  rail_interp i_rail_i (
    .clk          (clk),
    .reset_i      (reset_i),
    .smp_valid_i  (smp_valid),
    .smp_i        (smp_i),
    .sym_strobe_i (sym_strobe),
    .mu_i         (mu),
    .rail_valid_o (rail_i_valid),
    .rail_o       (rail_i)
  );

  // quadrature rail, same strobe and mu
  rail_interp i_rail_q (
    .clk          (clk),
    .reset_i      (reset_i),
    .smp_valid_i  (smp_valid),
    .smp_i        (smp_q),
    .sym_strobe_i (sym_strobe),
    .mu_i         (mu),
    .rail_valid_o (rail_q_valid),
    .rail_o       (rail_q)
  );

  symbol_joiner #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_symbol_joiner (
    .clk          (clk),
    .reset_i      (reset_i),
    .sym_strobe_i (sym_strobe),
    .i_valid_i    (rail_i_valid),
    .i_sym_i      (rail_i),
    .q_valid_i    (rail_q_valid),
    .q_sym_i      (rail_q),
    .sym_ready_i  (sym_ready_i),
    .raw_ready_o  (raw_ready_o),
    .sym_valid_o  (sym_valid_o),
    .sym_i_o      (sym_i_o),
    .sym_q_o      (sym_q_o)
  );

endmodule

`default_nettype wire

//--- sim/timing_recovery_chk.sv
`timescale 1ns/1ps
`default_nettype none

// joiner protocol checks bound into symbol_joiner
module timing_recovery_chk #(
  parameter int FIFO_DEPTH = 4
) (
  input wire                             clk,
  input wire                             reset_i,
  input wire                             i_valid_i,
  input wire                             q_valid_i,
  input wire                             sym_valid_i,
  input wire                             sym_ready_i,
  input timing_pkg::sym_t                sym_i_i,
  input timing_pkg::sym_t                sym_q_i,
  input wire [$clog2(FIFO_DEPTH+1)-1:0]  fill_i   // queue occupancy
);

  int fail_cnt;  // assertion failures so far

  // ----------------------------------------
  // rails share strobe and mu
  // ----------------------------------------
  a_rails_aligned : assert property (
    @(posedge clk) disable iff (reset_i) i_valid_i == q_valid_i
  ) else begin
    $error("I and Q rail valids differ");
    fail_cnt++;
  end

  // head held until taken
  a_out_hold : assert property (
    @(posedge clk) disable iff (reset_i)
    sym_valid_i && !sym_ready_i |=> sym_valid_i && $stable(sym_i_i) && $stable(sym_q_i)
  ) else begin
    $error("output symbol changed or dropped before it was taken");
    fail_cnt++;
  end

  // credits keep writes off a full queue
  a_no_full_write : assert property (
    @(posedge clk) disable iff (reset_i)
    i_valid_i && q_valid_i |-> fill_i < FIFO_DEPTH
  ) else begin
    $error("queue write while the queue is full");
    fail_cnt++;
  end

endmodule

`default_nettype wire

//--- sim/tb_timing_recovery.sv
`timescale 1ns/1ps
`default_nettype none

module tb_timing_recovery;

  localparam int PHASE_W   = 16;
  localparam int PHASE_MOD = 1 << PHASE_W;
  localparam int TIMEOUT   = 200;  // cycles allowed per wait

  logic                 clk;
  logic                 reset_i;
  logic                 raw_valid_i;
  timing_pkg::sample_t  raw_i_i;
  timing_pkg::sample_t  raw_q_i;
  logic [PHASE_W-1:0]   step_i;
  timing_pkg::mu_gain_t mu_gain_i;
  logic                 sym_ready_i;
  logic                 raw_ready_o;
  logic                 sym_valid_o;
  timing_pkg::sym_t     sym_i_o;
  timing_pkg::sym_t     sym_q_o;

  timing_recovery_top #(.PHASE_W(PHASE_W), .FIFO_DEPTH(4)) i_timing_recovery_top (
    .clk(clk), .reset_i(reset_i), .raw_valid_i(raw_valid_i), .raw_i_i(raw_i_i),
    .raw_q_i(raw_q_i), .step_i(step_i), .mu_gain_i(mu_gain_i), .sym_ready_i(sym_ready_i),
    .raw_ready_o(raw_ready_o), .sym_valid_o(sym_valid_o), .sym_i_o(sym_i_o), .sym_q_o(sym_q_o)
  );

  // joiner checker reads the internal fill count
  bind symbol_joiner timing_recovery_chk #(.FIFO_DEPTH(FIFO_DEPTH)) i_joiner_chk (
    .clk(clk), .reset_i(reset_i), .i_valid_i(i_valid_i), .q_valid_i(q_valid_i),
    .sym_valid_i(sym_valid_o), .sym_ready_i(sym_ready_i), .sym_i_i(sym_i_o),
    .sym_q_i(sym_q_o), .fill_i(fill_q)
  );

  int unsigned      lcg_state = 93405;
  int               acc_m;                 // model accumulator
  int               prev_i_m;              // model history starts at zero
  int               prev_q_m;
  int               cycle;                 // rising edges seen
  bit               lat_check;             // latency checked on isolated symbols
  bit               ready_random;          // jitter sym_ready_i
  int               err_value;
  int               err_other;
  int               n_checked;
  int               n_lat;
  timing_pkg::sym_t exp_i_q[$];            // expected symbols in order
  timing_pkg::sym_t exp_q_q[$];
  int               exp_cyc_q[$];          // acceptance edge of each
  bit               exp_lat_q[$];

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state >> 8;
  endfunction

  // weighted sum of newest and previous with floor of /64
  function automatic int interp(input int newest, input int prev, input int mu);
    return (newest * (256 - mu) + prev * mu) >>> 6;
  endfunction

  // one accepted raw sample queues a symbol on accumulator wrap
  function automatic void ref_accept(input int s_i, input int s_q);
    int sum;
    int mu;
    sum   = acc_m + int'(step_i);
    acc_m = sum % PHASE_MOD;
    if (sum >= PHASE_MOD) begin
      mu = ((acc_m >> (PHASE_W - 8)) * int'(mu_gain_i)) >> 8;
      if (mu > 255) mu = 255;                  // gain above 1.0 clips
      exp_i_q.push_back(timing_pkg::sym_t'(interp(s_i, prev_i_m, mu)));
      exp_q_q.push_back(timing_pkg::sym_t'(interp(s_q, prev_q_m, mu)));
      exp_cyc_q.push_back(cycle);              // next edge reads the same count
      exp_lat_q.push_back(lat_check);
    end
    prev_i_m = s_i;
    prev_q_m = s_q;
  endfunction

  // ----------------------------------------
  // stimulus tasks drive on the falling edge
  // ----------------------------------------
  task automatic ready_jitter();
    if (ready_random) sym_ready_i = (lcg_next() % 4) != 0;  // high 3 of 4
  endtask

  task automatic offer_sample(input int s_i, input int s_q, output bit taken);
    raw_valid_i = 1'b1;
    raw_i_i     = timing_pkg::sample_t'(s_i);
    raw_q_i     = timing_pkg::sample_t'(s_q);
    taken       = raw_ready_o;   // can't change before the next rising edge
    if (taken) ref_accept(raw_i_i, raw_q_i);
    ready_jitter();
    @(negedge clk);
    raw_valid_i = 1'b0;
  endtask

  task automatic send_sample(input int s_i, input int s_q);
    bit taken;
    int n;
    taken = 1'b0;
    n     = 0;
    while (!taken && n < TIMEOUT) begin
      offer_sample(s_i, s_q, taken);
      n++;
    end
    if (!taken) begin
      $display("timeout at %0t: raw sample never accepted", $time);
      err_other++;
    end
  endtask

  task automatic idle(input int n);
    raw_valid_i = 1'b0;
    repeat (n) begin
      ready_jitter();
      @(negedge clk);
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_i_q.size() != 0 && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (exp_i_q.size() != 0) begin
      $display("timeout at %0t: %0d expected symbols never came out", $time, exp_i_q.size());
      err_other++;
    end
  endtask

  // ----------------------------------------
  // output compare
  // ----------------------------------------
  always @(posedge clk) begin : compare_out
    timing_pkg::sym_t want_i;
    timing_pkg::sym_t want_q;
    int               acc_cyc;
    bit               lat;
    if (!reset_i && sym_valid_o && sym_ready_i) begin
      if (exp_i_q.size() == 0) begin
        $display("symbol taken at %0t while none was expected", $time);
        err_other++;
      end else begin
        want_i  = exp_i_q.pop_front();
        want_q  = exp_q_q.pop_front();
        acc_cyc = exp_cyc_q.pop_front();
        lat     = exp_lat_q.pop_front();
        n_checked++;
        if (sym_i_o !== want_i) begin
          $display("** Error at %0t: sym_i_o = %0d, expected %0d", $time, sym_i_o, want_i);
          err_value++;
        end
        if (sym_q_o !== want_q) begin
          $display("** Error at %0t: sym_q_o = %0d, expected %0d", $time, sym_q_o, want_q);
          err_value++;
        end
        if (lat) n_lat++;
        if (lat && cycle - acc_cyc != 4) begin
          $display("symbol at %0t took %0d cycles instead of 4", $time, cycle - acc_cyc);
          err_other++;
        end
      end
    end
  end

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin
    int n;
    int n_assert;
    bit taken;
    bit stalled;
    reset_i     = 1'b1;
    raw_valid_i = 1'b0;
    raw_i_i     = '0;
    raw_q_i     = '0;
    step_i      = 16384;     // 4 samples per symbol
    mu_gain_i   = 256;       // unity
    sym_ready_i = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset_i = 1'b0;

    // idle outputs after reset
    if (sym_valid_o !== 1'b0) begin
      $display("** Error at %0t: sym_valid_o = %b, expected 0", $time, sym_valid_o);
      err_value++;
    end
    if (raw_ready_o !== 1'b1) begin
      $display("** Error at %0t: raw_ready_o = %b, expected 1", $time, raw_ready_o);
      err_value++;
    end

    // ramp with mu always 0
    for (int k = 0; k < 40; k++) send_sample(k * 1000 - 20000, 15000 - k * 700);
    wait_drain();

    // random data, steps, gains, gaps and ready
    ready_random = 1'b1;
    for (int k = 0; k < 400; k++) begin
      if (k % 16 == 0) begin
        step_i    = PHASE_W'(3000 + lcg_next() % 50000);
        mu_gain_i = timing_pkg::mu_gain_t'(128 + lcg_next() % 900);
      end
      send_sample(int'(lcg_next() % 65536) - 32768, int'(lcg_next() % 65536) - 32768);
      if (lcg_next() % 3 == 0) idle(1 + int'(lcg_next() % 3));
    end
    ready_random = 1'b0;
    sym_ready_i  = 1'b1;
    wait_drain();

    // back-pressure until input stalls
    sym_ready_i = 1'b0;
    step_i      = 16384;
    mu_gain_i   = 256;
    stalled     = 1'b0;
    n           = 0;
    while (!stalled && n < TIMEOUT) begin
      offer_sample(n * 321 - 9000, 7000 - n * 123, taken);
      stalled = !taken;
      n++;
    end
    if (!stalled) begin
      $display("raw_ready_o never fell while sym_ready_i was low");
      err_other++;
    end
    idle(10);
    if (raw_ready_o !== 1'b0) begin
      $display("** Error at %0t: raw_ready_o = %b, expected 0", $time, raw_ready_o);
      err_value++;
    end
    sym_ready_i = 1'b1;
    wait_drain();

    // isolated symbols 8 samples apart
    lat_check = 1'b1;
    step_i    = 8192;
    for (int k = 0; k < 32; k++) send_sample(k * 500 - 8000, 9000 - k * 250);
    wait_drain();
    lat_check = 1'b0;
    if (n_lat == 0) begin
      $display("no symbol latency was measured");
      err_other++;
    end

    idle(5);
    n_assert = i_timing_recovery_top.i_symbol_joiner.i_joiner_chk.fail_cnt;
    $display("symbols checked %0d, value errors %0d, other errors %0d, assertion failures %0d",
             n_checked, err_value, err_other, n_assert);
    if (err_value + err_other + n_assert == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
verilog/timing_pkg.sv
verilog/symbol_nco.sv
verilog/rail_interp.sv
verilog/symbol_joiner.sv
verilog/timing_recovery_top.sv
sim/timing_recovery_chk.sv
sim/tb_timing_recovery.sv

//--- run_sim.sh
#!/bin/sh
# build and run the timing recovery testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f \
  --top-module tb_timing_recovery -o tb_timing_recovery \
  || { echo "build failed"; exit 1; }

out=$(./obj_dir/tb_timing_recovery 2>&1)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx "Done: no errors" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
